// File: rtl/bxn_counter.sv
`timescale 1ns/1ns

module bxn_counter (
  input  logic                      clock,
  input  logic                      bxn_preset,    // Sync reset, active high
  input  logic                      bc0,           // Received bunch crossing zero
  input  logic                      resync,        // Reload request
  input  logic [ttc_pkg::mxbxn-1:0] bxn_offset,    // Count loaded on resync
  output logic [ttc_pkg::mxbxn-1:0] bxn,           // Local bunch crossing
  output logic                      bx0_local,     // Local count at zero
  output logic                      bxn_wrap,      // Last crossing of the orbit
  output logic                      bxn_sync_err,  // Latched sync error
  output logic                      bx0_sync_err   // Sync error or load strobe
);

  import ttc_pkg::*;

  logic [mxbxn-1:0] bxn_offset_lim;  // Offset clipped to a real crossing
  logic             bxn_hold;        // Waiting for first BC0
  logic             bxn_load;        // Load offset this cycle
  logic             bxn_load_q;      // Load happened last cycle
  logic             bxn_sync;        // Count sits at the offset

  // ----------------------------
  // Offset limit
  // ----------------------------

  // Anything past the last crossing is pinned to 3563
  // Registered, so a new offset lands one cycle later
  always_ff @(posedge clock) begin
    if (bxn_offset >= lhc_cycle) begin
      bxn_offset_lim <= lhc_cycle - 1'b1;
    end else begin
      bxn_offset_lim <= bxn_offset;
    end
  end

  // ----------------------------
  // Hold until first BC0
  // ----------------------------

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      bxn_hold <= 1'b1;  // Armed by reset
    end else if (bc0) begin
      bxn_hold <= 1'b0;  // Released by BC0
    end
  end

  // Load while held or on resync, BC0 in the same cycle wins
  assign bxn_load = ((hold_until_bx0 && bxn_hold) || resync) && !bc0;

  // ----------------------------
  // Counter
  // ----------------------------

  assign bxn_wrap  = (bxn == lhc_cycle - 1'b1);  // 3563
  assign bx0_local = (bxn == '0);

  // Reset parks the count at the offset as well
  always_ff @(posedge clock) begin
    if (bxn_preset || bxn_load) begin
      bxn <= bxn_offset_lim;
    end else if (bxn_wrap) begin
      bxn <= '0;
    end else begin
      bxn <= bxn + 1'b1;
    end
  end

  // Right after a load the count already equals the offset;
  // the first real check comes one orbit later
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      bxn_load_q <= 1'b0;
    end else begin
      bxn_load_q <= bxn_load;
    end
  end

  // ----------------------------
  // Sync error
  // ----------------------------

  assign bxn_sync = (bxn == bxn_offset_lim);  // Expected BC0 position

  always_ff @(posedge clock) begin
    if (bxn_preset || bxn_load) begin
      bxn_sync_err <= 1'b0;                      // Cleared by a load
    end else if (bc0) begin
      bxn_sync_err <= !bxn_sync || bxn_sync_err; // BC0 off the local position
    end else if (bxn_sync && !bxn_load_q) begin
      bxn_sync_err <= 1'b1;                      // Local position with no BC0
    end
  end

  // Load shows as a one-cycle strobe on top of the latched error
  assign bx0_sync_err = bxn_sync_err || bxn_load;

  // ----------------------------
  // Checks
  // ----------------------------

  a_bxn_range : assert property (
    @(posedge clock) disable iff (bxn_preset)
    bxn < lhc_cycle
  ) else $error("bxn_counter: bxn %0d out of range at %0t", bxn, $time);

  a_bxn_step : assert property (
    @(posedge clock) disable iff (bxn_preset)
    (!bxn_load && !bxn_wrap) |=> (bxn == $past(bxn) + 1'b1)
  ) else $error("bxn_counter: bxn skipped to %0d at %0t", bxn, $time);

endmodule

// File: rtl/ttc_cmd_decode.sv
`timescale 1ns/1ns

module ttc_cmd_decode (
  input  logic       clock,
  input  logic       bxn_preset,  // Sync reset, active high
  input  logic [7:0] cmd,         // Broadcast command byte
  input  logic       cmd_strobe,  // Byte valid this cycle
  input  logic       l1a,         // Level-1 accept
  output logic       bc0,         // Bunch crossing zero pulse
  output logic       ec0,         // Event counter zero pulse
  output logic       oc0,         // Orbit counter zero pulse
  output logic       resync,      // Resync pulse
  output logic       l1a_q        // Registered L1A
);

  import ttc_pkg::*;

  // ----------------------------
  // Input registers
  // ----------------------------

  ttc_cmd_u cmd_q;      // Last strobed byte
  logic     cmd_valid;  // Strobe delayed one cycle

  // Byte only moves on a strobe
  always_ff @(posedge clock) begin
    if (cmd_strobe) begin
      cmd_q.code <= cmd;
    end
  end

  // Strobe and L1A are control, cleared by reset
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      cmd_valid <= 1'b0;
      l1a_q     <= 1'b0;
    end else begin
      cmd_valid <= cmd_strobe;  // One cycle per strobe
      l1a_q     <= l1a;         // Fixed latency of one
    end
  end

  // ----------------------------
  // Decode
  // ----------------------------

  // Flag bits come from the field view
  assign bc0 = cmd_valid && cmd_q.fields.bc0_bit;
  assign ec0 = cmd_valid && cmd_q.fields.ec0_bit;

  // Resync and OC0 come from the whole-code view
  assign resync = cmd_valid && (cmd_q.code == cmd_resync);
  assign oc0    = cmd_valid && (cmd_q.code == cmd_oc0);

  // Both codes have bits 1:0 clear,
  // so they never fire BC0 or EC0 alongside

  // ----------------------------
  // Checks
  // ----------------------------

  // The counters downstream treat resync and OC0 as separate events
  a_resync_oc0_excl : assert property (
    @(posedge clock) disable iff (bxn_preset)
    !(resync && oc0)
  ) else $error("ttc_cmd_decode: resync and oc0 together at %0t", $time);

endmodule

// File: rtl/ttc_event_tagger.sv
`timescale 1ns/1ns

module ttc_event_tagger (
  input  logic                      clock,
  input  logic                      bxn_preset,  // Active high sync reset
  input  logic [ttc_pkg::mxbxn-1:0] bxn,         // Local bunch crossing
  input  logic                      bxn_wrap,    // Last crossing of the orbit
  input  logic                      l1a_q,       // Registered L1A
  input  logic                      ec0,         // Event counter zero
  input  logic                      oc0,         // Orbit counter zero
  input  logic                      resync,      // Clears both counters
  output logic [ttc_pkg::mxorb-1:0] orbit,       // Orbit count
  output logic                      tag_valid,   // One-cycle tag strobe
  output logic [ttc_pkg::mxbxn-1:0] tag_bxn,     // BXN at the L1A
  output logic [ttc_pkg::mxevt-1:0] tag_evt,     // Event number of the L1A
  output logic [ttc_pkg::mxorb-1:0] tag_orbit    // Orbit at the L1A
);

  import ttc_pkg::*;

  logic [mxevt-1:0] evt_count;  // Events since last clear
  logic [mxevt-1:0] evt_next;   // Count after this cycle
  logic             evt_clear;  // EC0 or resync
  logic             orb_clear;  // OC0 or resync

  assign evt_clear = ec0 || resync;
  assign orb_clear = oc0 || resync;

  // ----------------------------
  // Orbit counter
  // ----------------------------

  // Steps at the end of the wrap cycle, so it is new when bxn is 0
  always_ff @(posedge clock) begin
    if (bxn_preset || orb_clear) begin
      orbit <= '0;            // Clear beats a wrap
    end else if (bxn_wrap) begin
      orbit <= orbit + 1'b1;
    end
  end

  // ----------------------------
  // Event counter
  // ----------------------------

  // Clear applies first, so an L1A in the clear cycle is event 1
  assign evt_next = (evt_clear ? '0 : evt_count) + mxevt'(l1a_q);

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      evt_count <= '0;
    end else begin
      evt_count <= evt_next;
    end
  end

  // ----------------------------
  // Tag capture
  // ----------------------------

  // Strobe follows the L1A by one cycle
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      tag_valid <= 1'b0;
    end else begin
      tag_valid <= l1a_q;
    end
  end

  // Tag words only change on an L1A
  always_ff @(posedge clock) begin
    if (l1a_q) begin
      tag_bxn   <= bxn;       // Crossing of the L1A cycle
      tag_evt   <= evt_next;  // Already counts this event
      tag_orbit <= orbit;     // Orbit of the L1A cycle
    end
  end

  // ----------------------------
  // Checks
  // ----------------------------

  // Event numbering starts at 1 after any clear
  a_tag_evt_nonzero : assert property (
    @(posedge clock) disable iff (bxn_preset)
    tag_valid |-> (tag_evt != '0)
  ) else $error("ttc_event_tagger: tag_evt is 0 at %0t", $time);

endmodule

// File: rtl/ttc_pkg.sv
package ttc_pkg;

  // ----------------------------
  // Counter widths
  // ----------------------------

  localparam int mxbxn = 12;  // Bunch crossing counter, 0 to 3563
  localparam int mxevt = 24;  // L1A event counter
  localparam int mxorb = 16;  // Orbit counter

  // ----------------------------
  // LHC machine constants
  // ----------------------------

  // Bunch crossings per orbit, one more than the highest BXN
  localparam logic [mxbxn-1:0] lhc_cycle = 12'd3564;

  // Keep loading the offset after reset until the first BC0 shows up
  localparam logic hold_until_bx0 = 1'b1;

  // ----------------------------
  // Broadcast command codes
  // ----------------------------

  // Whole-byte codes, low two bits clear so they never alias BC0/EC0
  localparam logic [7:0] cmd_resync = 8'h04;  // Resync, reload BXN offset
  localparam logic [7:0] cmd_oc0    = 8'h08;  // Orbit counter zero

  // Broadcast byte, read either as one code or as separate flag bits
  typedef union packed {
    logic [7:0] code;       // Full command code
    struct packed {
      logic [5:0] user;     // User defined upper bits
      logic       ec0_bit;  // Event counter zero
      logic       bc0_bit;  // Bunch crossing zero
    } fields;
  } ttc_cmd_u;

  // BC0 sits in bit 0, EC0 in bit 1
  // A byte may carry both flags at once
  // Resync and OC0 only ever appear as whole codes

endpackage

// File: rtl/ttc_top.sv
`timescale 1ns/1ns

module ttc_top (
  input  logic                      clock,
  input  logic                      bxn_preset,    // Sync reset, active high
  input  logic [7:0]                cmd,           // Broadcast command byte
  input  logic                      cmd_strobe,    // Command valid
  input  logic                      l1a,           // Level-1 accept
  input  logic [ttc_pkg::mxbxn-1:0] bxn_offset,    // BXN loaded on resync
  output logic [ttc_pkg::mxbxn-1:0] bxn,           // Local bunch crossing
  output logic                      bx0_local,     // Local BXN at zero
  output logic                      bxn_sync_err,  // Latched sync error
  output logic                      bx0_sync_err,  // Sync error or load
  output logic [ttc_pkg::mxorb-1:0] orbit,         // Orbit count
  output logic                      tag_valid,     // L1A tag strobe
  output logic [ttc_pkg::mxbxn-1:0] tag_bxn,       // Tagged crossing
  output logic [ttc_pkg::mxevt-1:0] tag_evt,       // Tagged event number
  output logic [ttc_pkg::mxorb-1:0] tag_orbit      // Tagged orbit
);

  // ----------------------------
  // Decoder outputs
  // ----------------------------

  logic bc0;       // Bunch crossing zero
  logic ec0;       // Event counter zero
  logic oc0;       // Orbit counter zero
  logic resync;    // Counter reload
  logic l1a_q;     // L1A, one cycle late
  logic bxn_wrap;  // Counter at 3563

  // Input side, one cycle of latency on every path
  ttc_cmd_decode i_ttc_cmd_decode (
    .clock      (clock),
    .bxn_preset (bxn_preset),
    .cmd        (cmd),
    .cmd_strobe (cmd_strobe),
    .l1a        (l1a),
    .bc0        (bc0),
    .ec0        (ec0),
    .oc0        (oc0),
    .resync     (resync),
    .l1a_q      (l1a_q)
  );

  // Bunch counter, loads on resync and checks BC0 alignment
  bxn_counter i_bxn_counter (
    .clock        (clock),
    .bxn_preset   (bxn_preset),
    .bc0          (bc0),
    .resync       (resync),
    .bxn_offset   (bxn_offset),
    .bxn          (bxn),
    .bx0_local    (bx0_local),
    .bxn_wrap     (bxn_wrap),
    .bxn_sync_err (bxn_sync_err),
    .bx0_sync_err (bx0_sync_err)
  );

  // Output side, orbit and event counts plus the L1A tag
  ttc_event_tagger i_ttc_event_tagger (
    .clock      (clock),
    .bxn_preset (bxn_preset),
    .bxn        (bxn),
    .bxn_wrap   (bxn_wrap),
    .l1a_q      (l1a_q),
    .ec0        (ec0),
    .oc0        (oc0),
    .resync     (resync),
    .orbit      (orbit),
    .tag_valid  (tag_valid),
    .tag_bxn    (tag_bxn),
    .tag_evt    (tag_evt),
    .tag_orbit  (tag_orbit)
  );

endmodule

// File: tb.f
rtl/ttc_pkg.sv
rtl/ttc_cmd_decode.sv
rtl/bxn_counter.sv
rtl/ttc_event_tagger.sv
rtl/ttc_top.sv
tb/ttc_tb.sv

// File: tb/ttc_tb.sv
`timescale 1ns/1ns

module ttc_tb;

  import ttc_pkg::*;

  // Flag bytes built from the bit positions of the command byte
  localparam logic [7:0] byte_bc0 = 8'h01;  // Bit 0
  localparam logic [7:0] byte_ec0 = 8'h02;  // Bit 1

  // About six orbits of tests, plus a margin of 30 orbits
  localparam int test_cycles = 6 * int'(lhc_cycle) + 1000;
  localparam int watchdog_ns = (test_cycles + 30 * int'(lhc_cycle)) * 10;

  logic             clock = 1'b0;
  logic             bxn_preset;
  logic [7:0]       cmd;
  logic             cmd_strobe;
  logic             l1a;
  logic [mxbxn-1:0] bxn_offset;
  logic [mxbxn-1:0] bxn;
  logic             bx0_local;
  logic             bxn_sync_err;
  logic             bx0_sync_err;
  logic [mxorb-1:0] orbit;
  logic             tag_valid;
  logic [mxbxn-1:0] tag_bxn;
  logic [mxevt-1:0] tag_evt;
  logic [mxorb-1:0] tag_orbit;

  int          n_mismatch = 0;         // Wrong values
  int          n_other    = 0;         // Timeouts and missing strobes
  int          n_tags     = 0;         // Tags seen by the checker
  logic [31:0] lfsr       = 32'hdef0;  // Stimulus seed

  always #5 clock = ~clock;  // 10 ns period

  ttc_top i_ttc_top (
    .clock        (clock),
    .bxn_preset   (bxn_preset),
    .cmd          (cmd),
    .cmd_strobe   (cmd_strobe),
    .l1a          (l1a),
    .bxn_offset   (bxn_offset),
    .bxn          (bxn),
    .bx0_local    (bx0_local),
    .bxn_sync_err (bxn_sync_err),
    .bx0_sync_err (bx0_sync_err),
    .orbit        (orbit),
    .tag_valid    (tag_valid),
    .tag_bxn      (tag_bxn),
    .tag_evt      (tag_evt),
    .tag_orbit    (tag_orbit)
  );

  // ----------------------------
  // Reference model
  // ----------------------------

  logic             d_valid = 1'b0;  // Strobe, one cycle late
  logic [7:0]       d_cmd   = '0;    // Last strobed byte
  logic             d_l1a   = 1'b0;  // L1A, one cycle late
  logic             m_hold, m_tag_valid;
  logic [mxbxn-1:0] m_off_lim, m_bxn, m_tag_bxn;
  logic [mxorb-1:0] m_orbit, m_tag_orbit;
  logic [mxevt-1:0] m_evt, m_tag_evt;
  logic             m_bc0, m_ec0, m_oc0, m_resync;

  assign m_bc0    = d_valid && d_cmd[0];
  assign m_ec0    = d_valid && d_cmd[1];
  assign m_resync = d_valid && (d_cmd == cmd_resync);
  assign m_oc0    = d_valid && (d_cmd == cmd_oc0);

  always @(posedge clock) begin : ref_model
    logic             m_load;
    logic [mxevt-1:0] e_next;
    m_load = (m_hold || m_resync) && !m_bc0;               // BC0 beats resync
    e_next = ((m_ec0 || m_resync) ? '0 : m_evt) + mxevt'(d_l1a);  // Clear first
    m_off_lim <= (bxn_offset > lhc_cycle - 1) ? lhc_cycle - 1 : bxn_offset;
    if (cmd_strobe) d_cmd <= cmd;
    if (bxn_preset) begin
      d_valid     <= 1'b0;
      d_l1a       <= 1'b0;
      m_hold      <= 1'b1;
      m_bxn       <= m_off_lim;  // Parked at the offset
      m_orbit     <= '0;
      m_evt       <= '0;
      m_tag_valid <= 1'b0;
    end else begin
      d_valid <= cmd_strobe;
      d_l1a   <= l1a;
      if (m_bc0) m_hold <= 1'b0;
      if (m_load) m_bxn <= m_off_lim;
      else if (m_bxn == lhc_cycle - 1) m_bxn <= '0;  // Wrap 3563 to 0
      else m_bxn <= m_bxn + 1'b1;
      if (m_oc0 || m_resync) m_orbit <= '0;
      else if (m_bxn == lhc_cycle - 1) m_orbit <= m_orbit + 1'b1;
      m_evt       <= e_next;
      m_tag_valid <= d_l1a;
      if (d_l1a) begin
        m_tag_bxn   <= m_bxn;
        m_tag_evt   <= e_next;
        m_tag_orbit <= m_orbit;
      end
    end
  end

  // ----------------------------
  // Checker and helpers
  // ----------------------------

  task automatic report_mismatch(input string what, input longint got, input longint exp);
    n_mismatch++;
    $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clock) begin
    if (!bxn_preset) begin
      assert (bxn == m_bxn) else report_mismatch("bxn", bxn, m_bxn);
      assert (bx0_local == (m_bxn == '0)) else report_mismatch("bx0_local", bx0_local, m_bxn == '0);
      assert (orbit == m_orbit) else report_mismatch("orbit", orbit, m_orbit);
      assert (tag_valid == m_tag_valid) else report_mismatch("tag_valid", tag_valid, m_tag_valid);
      if (tag_valid) begin
        n_tags++;
        assert (tag_bxn == m_tag_bxn) else report_mismatch("tag_bxn", tag_bxn, m_tag_bxn);
        assert (tag_evt == m_tag_evt) else report_mismatch("tag_evt", tag_evt, m_tag_evt);
        assert (tag_orbit == m_tag_orbit) else report_mismatch("tag_orbit", tag_orbit, m_tag_orbit);
      end
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int rand_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  function automatic logic [mxbxn-1:0] rand_offset();
    return mxbxn'(rand_bits(mxbxn) % int'(lhc_cycle));  // Always a real crossing
  endfunction

  task automatic tick();
    @(posedge clock);
    #1;  // Drive just after the edge
  endtask

  task automatic send_cmd(input logic [7:0] code);
    cmd        = code;
    cmd_strobe = 1'b1;
    tick();
    cmd_strobe = 1'b0;
    cmd        = '0;
  endtask

  task automatic wait_tag(input int limit);
    int n;
    n = 0;
    while (!tag_valid && n < limit) begin
      tick();
      n++;
    end
    assert (tag_valid) else begin
      n_other++;
      $display("error at %0t: no tag_valid within %0d cycles", $time, limit);
    end
  endtask

  // Leave the current zero first, then wait for the next one
  task automatic wait_bx0();
    int n;
    n = 0;
    while (bx0_local && n < 4) begin
      tick();
      n++;
    end
    while (!bx0_local && n < int'(lhc_cycle) + 4) begin
      tick();
      n++;
    end
    assert (bx0_local) else begin
      n_other++;
      $display("error at %0t: bx0_local never came back", $time);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // ----------------------------
  // Tests
  // ----------------------------

  task automatic test_hold_and_start();
    int zeros;
    zeros = 0;
    repeat (20) begin
      assert (bxn == bxn_offset) else report_mismatch("held bxn", bxn, bxn_offset);
      tick();
    end
    send_cmd(byte_bc0);  // Releases the hold
    repeat (2 * int'(lhc_cycle)) begin
      tick();
      if (bx0_local) zeros++;
    end
    assert (zeros == 2) else report_mismatch("bx0_local count in two orbits", zeros, 2);
  endtask

  task automatic test_aligned_bc0();
    logic [mxbxn-1:0] off;
    off        = rand_offset();
    bxn_offset = off;
    tick();
    send_cmd(cmd_resync);  // Now in the load cycle
    assert (bx0_sync_err) else report_mismatch("bx0_sync_err on load", bx0_sync_err, 1);
    repeat (int'(lhc_cycle)) begin
      tick();
      assert (!bxn_sync_err && !bx0_sync_err)
        else report_mismatch("sync flags", {bxn_sync_err, bx0_sync_err}, 0);
    end
    send_cmd(byte_bc0);  // One orbit after the load
    assert (bxn == off) else report_mismatch("bxn at aligned BC0", bxn, off);
    repeat (10) begin
      tick();
      assert (!bxn_sync_err) else report_mismatch("bxn_sync_err", bxn_sync_err, 0);
    end
  endtask

  task automatic test_misaligned_bc0();
    send_cmd(byte_bc0);
    assert (bxn != bxn_offset) else begin
      n_other++;
      $display("error at %0t: BC0 meant to be misaligned hit the offset", $time);
    end
    repeat (200) begin
      tick();
      assert (bxn_sync_err) else report_mismatch("latched bxn_sync_err", bxn_sync_err, 1);
    end
    send_cmd(cmd_resync);
    tick();  // Load has landed
    assert (!bxn_sync_err) else report_mismatch("bxn_sync_err after resync", bxn_sync_err, 0);
  endtask

  task automatic test_offset_limit();
    bxn_offset = 12'd4000;
    send_cmd(cmd_resync);
    tick();
    assert (bxn == lhc_cycle - 1) else report_mismatch("limited offset", bxn, lhc_cycle - 1);
    bxn_offset = rand_offset();
  endtask

  task automatic test_l1a_tags();
    int start;
    int sent;
    int gap;
    int n;
    start = n_tags;
    sent  = 0;
    for (int i = 0; i < 40; i++) begin
      l1a = 1'b1;
      tick();
      sent++;
      l1a = 1'b0;
      gap = (i < 3) ? 0 : rand_bits(3);  // First ones back to back
      repeat (gap) tick();
    end
    n = 0;
    while (n_tags - start < sent && n < 8) begin
      tick();
      n++;
    end
    assert (n_tags - start == sent) else report_mismatch("tag count", n_tags - start, sent);
  endtask

  task automatic test_counter_clears();
    cmd        = byte_ec0;  // EC0 and L1A in the same cycle
    cmd_strobe = 1'b1;
    l1a        = 1'b1;
    tick();
    cmd_strobe = 1'b0;
    l1a        = 1'b0;
    cmd        = '0;
    wait_tag(4);
    assert (tag_evt == 1) else report_mismatch("tag_evt after EC0", tag_evt, 1);
    l1a = 1'b1;
    tick();
    l1a = 1'b0;
    wait_tag(4);
    assert (tag_evt == 2) else report_mismatch("second tag_evt", tag_evt, 2);
    send_cmd(cmd_oc0);
    tick();
    assert (orbit == 0) else report_mismatch("orbit after OC0", orbit, 0);
    wait_bx0();
    assert (orbit == 1) else report_mismatch("orbit after one wrap", orbit, 1);
    wait_bx0();
    assert (orbit == 2) else report_mismatch("orbit after two wraps", orbit, 2);
  endtask

  // ----------------------------
  // Main sequence and watchdog
  // ----------------------------

  initial begin
    cmd        = '0;
    cmd_strobe = 1'b0;
    l1a        = 1'b0;
    bxn_offset = rand_offset();
    bxn_preset = 1'b1;
    repeat (8) @(posedge clock);
    #1 bxn_preset = 1'b0;
    test_hold_and_start();
    test_aligned_bc0();
    test_misaligned_bc0();
    test_offset_limit();
    test_l1a_tags();
    test_counter_clears();
    finish_run();
  end

  initial begin
    #(watchdog_ns);
    n_other++;
    $display("error at %0t: run did not finish in time", $time);
    finish_run();
  end

endmodule
